//--- Makefile
SOURCES := $(shell cat vlog.f)

obj_dir/Virf_tb: vlog.f $(SOURCES)
	verilator --binary --top-module irf_tb -f vlog.f

run: obj_dir/Virf_tb
	@out="$$(./obj_dir/Virf_tb)"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- common/irf_pkg.sv
package irf_pkg;

   // thread and register geometry
   localparam int NUM_THREADS     = 4;
   localparam int REGS_PER_THREAD = 32;
   localparam int NUM_ACTIVE      = NUM_THREADS * REGS_PER_THREAD;

   // swap groups of 8 registers each
   localparam int GROUP_SIZE = 8;
   localparam int ODD_BASE   = 8;    // r8..r15
   localparam int LOCAL_BASE = 16;   // r16..r23
   localparam int EVEN_BASE  = 24;   // r24..r31

   // backing store depths
   localparam int NUM_LO_WINDOWS = 8;   // locals follow the full cwp
   localparam int NUM_HI_WINDOWS = 4;   // odd and even use a 2-bit pointer
   localparam int LOCAL_DEPTH    = NUM_THREADS * NUM_LO_WINDOWS * GROUP_SIZE;
   localparam int OUTER_DEPTH    = NUM_THREADS * NUM_HI_WINDOWS * GROUP_SIZE;

   typedef logic [1:0] tid_t;
   typedef logic [4:0] reg_addr_t;
   typedef logic [6:0] thr_reg_t;    // {tid, reg}
   typedef logic [2:0] cwp_t;
   typedef logic [1:0] e_cwp_t;
   typedef logic [2:0] grp_idx_t;

   // encoding doubles as the bit position in the engine's pending mask
   typedef enum logic [1:0] {
      ODD   = 2'd0,
      LOCAL = 2'd1,
      EVEN  = 2'd2
   } group_t;

endpackage

//--- regfile/irf_active_array.sv
`timescale 1ns/1ps

module irf_active_array #(
   parameter int DATA_WIDTH = 72
) (
   input  logic                  clk,
   input  logic                  rst,
   // read ports with s stage inputs
   input  irf_pkg::tid_t         tid,
   input  logic                  ren_1,
   input  logic                  ren_2,
   input  logic                  ren_3,
   input  irf_pkg::reg_addr_t    rs_1,
   input  irf_pkg::reg_addr_t    rs_2,
   input  irf_pkg::reg_addr_t    rs_3,
   output logic [DATA_WIDTH-1:0] rd_data_1,
   output logic [DATA_WIDTH-1:0] rd_data_2,
   output logic [DATA_WIDTH-1:0] rd_data_3,
   // write ports
   input  logic                  wen_1,
   input  logic                  wen_2,
   input  irf_pkg::tid_t         wr_tid_1,
   input  irf_pkg::tid_t         wr_tid_2,
   input  irf_pkg::reg_addr_t    wr_reg_1,
   input  irf_pkg::reg_addr_t    wr_reg_2,
   input  logic [DATA_WIDTH-1:0] wr_data_1,
   input  logic [DATA_WIDTH-1:0] wr_data_2,
   // swap engine access
   input  irf_pkg::thr_reg_t     eng_rd_addr,
   output logic [DATA_WIDTH-1:0] eng_rd_data,
   input  logic                  eng_wen,
   input  irf_pkg::thr_reg_t     eng_wr_addr,
   input  logic [DATA_WIDTH-1:0] eng_wr_data
);

   // 4 threads x 32 registers indexed by {tid, reg}
   logic [DATA_WIDTH-1:0] regs [irf_pkg::NUM_ACTIVE];

   // d stage copies of the read request
   logic                  ren_1_d;
   logic                  ren_2_d;
   logic                  ren_3_d;
   irf_pkg::reg_addr_t    rs_1_d;
   irf_pkg::reg_addr_t    rs_2_d;
   irf_pkg::reg_addr_t    rs_3_d;
   irf_pkg::tid_t         tid_d;

   logic                  wr_ok_1;
   logic                  wr_ok_2;

   // r0 and disabled ports read as zero
   function automatic logic [DATA_WIDTH-1:0] read_word(
      input logic               en,
      input irf_pkg::tid_t      thr,
      input irf_pkg::reg_addr_t rs
   );
      logic [DATA_WIDTH-1:0] word;
      word = '0;
      if (en && rs != '0) begin
         word = regs[irf_pkg::thr_reg_t'({thr, rs})];
      end
      return word;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         ren_1_d <= 1'b0;
         ren_2_d <= 1'b0;
         ren_3_d <= 1'b0;
      end else begin
         ren_1_d <= ren_1;
         ren_2_d <= ren_2;
         ren_3_d <= ren_3;
      end
   end

   always_ff @(posedge clk) begin
      rs_1_d <= rs_1;
      rs_2_d <= rs_2;
      rs_3_d <= rs_3;
      tid_d  <= tid;
   end

   // second edge of the read sees all writes up to the sample edge
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_data_1 <= '0;
         rd_data_2 <= '0;
         rd_data_3 <= '0;
      end else begin
         rd_data_1 <= read_word(ren_1_d, tid_d, rs_1_d);
         rd_data_2 <= read_word(ren_2_d, tid_d, rs_2_d);
         rd_data_3 <= read_word(ren_3_d, tid_d, rs_3_d);
      end
   end

   assign wr_ok_1 = wen_1 && (wr_reg_1 != '0);
   assign wr_ok_2 = wen_2 && (wr_reg_2 != '0);

   // the later assignment wins so port 2 beats port 1 and the engine beats both
   always_ff @(posedge clk) begin
      if (wr_ok_1) begin
         regs[irf_pkg::thr_reg_t'({wr_tid_1, wr_reg_1})] <= wr_data_1;
      end
      if (wr_ok_2) begin
         regs[irf_pkg::thr_reg_t'({wr_tid_2, wr_reg_2})] <= wr_data_2;
      end
      if (eng_wen) begin
         regs[eng_wr_addr] <= eng_wr_data;
      end
   end

   assign eng_rd_data = regs[eng_rd_addr];   // combinational for the save step

endmodule

//--- source/irf_top.sv
`timescale 1ns/1ps

module irf_top #(
   parameter int DATA_WIDTH = 72
) (
   input  logic                  clk,
   input  logic                  rst,
   // read side
   input  irf_pkg::tid_t         tid,
   input  logic                  ren_1,
   input  logic                  ren_2,
   input  logic                  ren_3,
   input  irf_pkg::reg_addr_t    rs_1,
   input  irf_pkg::reg_addr_t    rs_2,
   input  irf_pkg::reg_addr_t    rs_3,
   output logic [DATA_WIDTH-1:0] rd_data_1,
   output logic [DATA_WIDTH-1:0] rd_data_2,
   output logic [DATA_WIDTH-1:0] rd_data_3,
   // write side
   input  logic                  wen_1,
   input  logic                  wen_2,
   input  irf_pkg::tid_t         wr_tid_1,
   input  irf_pkg::tid_t         wr_tid_2,
   input  irf_pkg::reg_addr_t    wr_reg_1,
   input  irf_pkg::reg_addr_t    wr_reg_2,
   input  logic [DATA_WIDTH-1:0] wr_data_1,
   input  logic [DATA_WIDTH-1:0] wr_data_2,
   // window swap command
   input  logic                  swap_req,
   output logic                  swap_ack,
   input  irf_pkg::tid_t         swap_tid,
   input  irf_pkg::cwp_t         old_cwp,
   input  irf_pkg::cwp_t         new_cwp,
   input  irf_pkg::e_cwp_t       old_e_cwp,
   input  irf_pkg::e_cwp_t       new_e_cwp,
   input  logic                  swap_odd,
   input  logic                  swap_local,
   input  logic                  swap_even
);

   // engine <-> active array
   irf_pkg::thr_reg_t     eng_rd_addr;
   logic [DATA_WIDTH-1:0] eng_rd_data;
   logic                  eng_wen;
   irf_pkg::thr_reg_t     eng_wr_addr;
   logic [DATA_WIDTH-1:0] eng_wr_data;

   // engine <-> window store
   irf_pkg::group_t       st_group;
   logic [7:0]            st_index;
   logic                  st_wen;
   logic [DATA_WIDTH-1:0] st_wr_data;
   logic [DATA_WIDTH-1:0] st_rd_data;

   irf_active_array #(.DATA_WIDTH(DATA_WIDTH)) u_array (
      .clk         (clk),
      .rst         (rst),
      .tid         (tid),
      .ren_1       (ren_1),
      .ren_2       (ren_2),
      .ren_3       (ren_3),
      .rs_1        (rs_1),
      .rs_2        (rs_2),
      .rs_3        (rs_3),
      .rd_data_1   (rd_data_1),
      .rd_data_2   (rd_data_2),
      .rd_data_3   (rd_data_3),
      .wen_1       (wen_1),
      .wen_2       (wen_2),
      .wr_tid_1    (wr_tid_1),
      .wr_tid_2    (wr_tid_2),
      .wr_reg_1    (wr_reg_1),
      .wr_reg_2    (wr_reg_2),
      .wr_data_1   (wr_data_1),
      .wr_data_2   (wr_data_2),
      .eng_rd_addr (eng_rd_addr),
      .eng_rd_data (eng_rd_data),
      .eng_wen     (eng_wen),
      .eng_wr_addr (eng_wr_addr),
      .eng_wr_data (eng_wr_data)
   );

   irf_swap_engine #(.DATA_WIDTH(DATA_WIDTH)) u_engine (
      .clk         (clk),
      .rst         (rst),
      .swap_req    (swap_req),
      .swap_ack    (swap_ack),
      .swap_tid    (swap_tid),
      .old_cwp     (old_cwp),
      .new_cwp     (new_cwp),
      .old_e_cwp   (old_e_cwp),
      .new_e_cwp   (new_e_cwp),
      .swap_odd    (swap_odd),
      .swap_local  (swap_local),
      .swap_even   (swap_even),
      .eng_rd_addr (eng_rd_addr),
      .eng_rd_data (eng_rd_data),
      .eng_wen     (eng_wen),
      .eng_wr_addr (eng_wr_addr),
      .eng_wr_data (eng_wr_data),
      .st_group    (st_group),
      .st_index    (st_index),
      .st_wen      (st_wen),
      .st_wr_data  (st_wr_data),
      .st_rd_data  (st_rd_data)
   );

   irf_window_store #(.DATA_WIDTH(DATA_WIDTH)) u_store (
      .clk        (clk),
      .st_group   (st_group),
      .st_index   (st_index),
      .st_wen     (st_wen),
      .st_wr_data (st_wr_data),
      .st_rd_data (st_rd_data)
   );

endmodule

//--- testbench/irf_tb.sv
`timescale 1ns/1ps

module irf_tb;

   localparam int DW          = 72;
   localparam int N_RANDOM    = 300;
   localparam int N_ZERO      = 8;
   localparam int N_CONFLICT  = 16;
   localparam int N_ROUNDS    = 4;
   // reset, fill, directed loops, then swap rounds of at most about 140 cycles each
   localparam int PLAN_CYCLES = 3 + 64 + N_RANDOM + 2 * N_ZERO + 3 * N_CONFLICT
                                + 140 * N_ROUNDS + 10;
   localparam int CYCLE_LIMIT = 2 * PLAN_CYCLES;

   logic               clk = 1'b0;
   logic               rst;
   irf_pkg::tid_t      tid;
   logic               ren_1;
   logic               ren_2;
   logic               ren_3;
   irf_pkg::reg_addr_t rs_1;
   irf_pkg::reg_addr_t rs_2;
   irf_pkg::reg_addr_t rs_3;
   logic [DW-1:0]      rd_data_1;
   logic [DW-1:0]      rd_data_2;
   logic [DW-1:0]      rd_data_3;
   logic               wen_1;
   logic               wen_2;
   irf_pkg::tid_t      wr_tid_1;
   irf_pkg::tid_t      wr_tid_2;
   irf_pkg::reg_addr_t wr_reg_1;
   irf_pkg::reg_addr_t wr_reg_2;
   logic [DW-1:0]      wr_data_1;
   logic [DW-1:0]      wr_data_2;
   logic               swap_req;
   logic               swap_ack;
   irf_pkg::tid_t      swap_tid;
   irf_pkg::cwp_t      old_cwp;
   irf_pkg::cwp_t      new_cwp;
   irf_pkg::e_cwp_t    old_e_cwp;
   irf_pkg::e_cwp_t    new_e_cwp;
   logic               swap_odd;
   logic               swap_local;
   logic               swap_even;

   // reference model of the active registers and the three backing stores
   logic [DW-1:0] m_regs [irf_pkg::NUM_ACTIVE];
   logic [DW-1:0] m_loc  [irf_pkg::LOCAL_DEPTH];
   logic [DW-1:0] m_odd  [irf_pkg::OUTER_DEPTH];
   logic [DW-1:0] m_even [irf_pkg::OUTER_DEPTH];

   logic [DW-1:0] exp_1 = '0;   // read sampled at the last edge
   logic [DW-1:0] exp_2 = '0;
   logic [DW-1:0] exp_3 = '0;
   logic [31:0]   lfsr_state = 32'h6f5e;
   int            data_errs = 0;
   int            ack_errs = 0;
   int            cycles = 0;

   irf_top #(.DATA_WIDTH(DW)) dut0 (.*);

   always #50 clk = ~clk;

   initial begin
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("run timed out after %0d cycles", cycles);
      $display("Checks failed");
      $finish;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [DW-1:0] rand_bits(input int n);
      logic [DW-1:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[DW-2:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic irf_pkg::tid_t pick_tid(input logic avoid_en, input irf_pkg::tid_t avoid);
      irf_pkg::tid_t t;
      t = irf_pkg::tid_t'(rand_bits(2));
      if (avoid_en && t == avoid) t = t + 1'b1;   // keep off the swapping thread
      return t;
   endfunction

   function automatic logic [DW-1:0] model_read(input logic en, input irf_pkg::tid_t t,
                                                input irf_pkg::reg_addr_t r);
      if (!en || r == '0) return '0;
      return m_regs[{t, r}];
   endfunction

   // each group is saved under the old pointer and restored from the new one
   function automatic void model_swap(input irf_pkg::tid_t t, input irf_pkg::cwp_t oc, nc,
                                      input irf_pkg::e_cwp_t oe, ne, input logic [2:0] grp);
      irf_pkg::thr_reg_t a;
      int                base;
      for (int g = 0; g < 3; g++) begin
         if (!grp[g]) continue;
         base = (g == 0) ? irf_pkg::ODD_BASE : (g == 1) ? irf_pkg::LOCAL_BASE : irf_pkg::EVEN_BASE;
         for (int i = 0; i < irf_pkg::GROUP_SIZE; i++) begin
            a = {t, irf_pkg::reg_addr_t'(base + i)};
            case (g)
               0:       m_odd[{t, oc[2:1], 3'(i)}] = m_regs[a];
               1:       m_loc[{t, oc, 3'(i)}] = m_regs[a];
               default: m_even[{t, oe, 3'(i)}] = m_regs[a];
            endcase
         end
         for (int i = 0; i < irf_pkg::GROUP_SIZE; i++) begin
            a = {t, irf_pkg::reg_addr_t'(base + i)};
            case (g)
               0:       m_regs[a] = m_odd[{t, nc[2:1], 3'(i)}];
               1:       m_regs[a] = m_loc[{t, nc, 3'(i)}];
               default: m_regs[a] = m_even[{t, ne, 3'(i)}];
            endcase
         end
      end
   endfunction

   task automatic check_data(input string name, input logic [DW-1:0] got, input logic [DW-1:0] exp);
      if (got !== exp) begin
         data_errs++;
         $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_ack(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         ack_errs++;
         $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   // model the driven writes for one clock and check the read issued a cycle earlier
   task automatic tick();
      logic [DW-1:0] nxt_1;
      logic [DW-1:0] nxt_2;
      logic [DW-1:0] nxt_3;
      logic          req_sampled;
      if (wen_1 && wr_reg_1 != '0) m_regs[{wr_tid_1, wr_reg_1}] = wr_data_1;
      if (wen_2 && wr_reg_2 != '0) m_regs[{wr_tid_2, wr_reg_2}] = wr_data_2;   // port 2 last
      nxt_1 = model_read(ren_1, tid, rs_1);
      nxt_2 = model_read(ren_2, tid, rs_2);
      nxt_3 = model_read(ren_3, tid, rs_3);
      req_sampled = swap_req;
      @(posedge clk);
      #5;
      check_data("rd_data_1", rd_data_1, exp_1);
      check_data("rd_data_2", rd_data_2, exp_2);
      check_data("rd_data_3", rd_data_3, exp_3);
      exp_1 = nxt_1;
      exp_2 = nxt_2;
      exp_3 = nxt_3;
      if (!req_sampled) check_ack("swap_ack", swap_ack, 1'b0);   // no ack without a request
      ren_1 = 1'b0;
      ren_2 = 1'b0;
      ren_3 = 1'b0;
      wen_1 = 1'b0;
      wen_2 = 1'b0;
   endtask

   task automatic random_traffic(input logic avoid_en, input irf_pkg::tid_t avoid);
      tid       = pick_tid(avoid_en, avoid);
      ren_1     = 1'(rand_bits(1));
      ren_2     = 1'(rand_bits(1));
      ren_3     = 1'(rand_bits(1));
      rs_1      = irf_pkg::reg_addr_t'(rand_bits(5));
      rs_2      = irf_pkg::reg_addr_t'(rand_bits(5));
      rs_3      = irf_pkg::reg_addr_t'(rand_bits(5));
      wen_1     = 1'(rand_bits(1));
      wr_tid_1  = pick_tid(avoid_en, avoid);
      wr_reg_1  = irf_pkg::reg_addr_t'(rand_bits(5));
      wr_data_1 = rand_bits(DW);
      wen_2     = 1'(rand_bits(1));
      wr_tid_2  = pick_tid(avoid_en, avoid);
      wr_reg_2  = irf_pkg::reg_addr_t'(rand_bits(5));
      wr_data_2 = rand_bits(DW);
   endtask

   task automatic fill_thread(input irf_pkg::tid_t t);
      for (int r = 1; r < irf_pkg::REGS_PER_THREAD; r += 2) begin
         wen_1     = 1'b1;
         wr_tid_1  = t;
         wr_reg_1  = irf_pkg::reg_addr_t'(r);
         wr_data_1 = rand_bits(DW);
         wen_2     = (r + 1 < irf_pkg::REGS_PER_THREAD);
         wr_tid_2  = t;
         wr_reg_2  = irf_pkg::reg_addr_t'(r + 1);
         wr_data_2 = rand_bits(DW);
         tick();
      end
   endtask

   task automatic read_thread(input irf_pkg::tid_t t);
      for (int r = 1; r < irf_pkg::REGS_PER_THREAD; r += 3) begin
         tid   = t;
         ren_1 = 1'b1;
         rs_1  = irf_pkg::reg_addr_t'(r);
         ren_2 = (r + 1 < irf_pkg::REGS_PER_THREAD);
         rs_2  = irf_pkg::reg_addr_t'(r + 1);
         ren_3 = (r + 2 < irf_pkg::REGS_PER_THREAD);
         rs_3  = irf_pkg::reg_addr_t'(r + 2);
         tick();
      end
   endtask

   task automatic run_swap(input irf_pkg::tid_t t, input irf_pkg::cwp_t oc, nc,
                           input irf_pkg::e_cwp_t oe, ne, input logic [2:0] grp);
      check_ack("swap_ack", swap_ack, 1'b0);
      swap_tid   = t;
      old_cwp    = oc;
      new_cwp    = nc;
      old_e_cwp  = oe;
      new_e_cwp  = ne;
      swap_odd   = grp[0];
      swap_local = grp[1];
      swap_even  = grp[2];
      swap_req   = 1'b1;
      while (swap_ack !== 1'b1) begin
         random_traffic(1'b1, t);   // other threads keep running
         tick();
      end
      model_swap(t, oc, nc, oe, ne, grp);
      repeat (2) begin
         random_traffic(1'b1, t);
         tick();
         check_ack("swap_ack", swap_ack, 1'b1);   // held while the request stays up
      end
      swap_req = 1'b0;
      tick();
   endtask

   initial begin
      irf_pkg::tid_t      thr;
      irf_pkg::reg_addr_t r;
      irf_pkg::cwp_t      cwp_a;
      irf_pkg::e_cwp_t    e_a;
      logic [2:0]         grp;
      rst = 1'b1;
      tid = '0;
      ren_1 = 1'b0;
      ren_2 = 1'b0;
      ren_3 = 1'b0;
      rs_1 = '0;
      rs_2 = '0;
      rs_3 = '0;
      wen_1 = 1'b0;
      wen_2 = 1'b0;
      wr_tid_1 = '0;
      wr_tid_2 = '0;
      wr_reg_1 = '0;
      wr_reg_2 = '0;
      wr_data_1 = '0;
      wr_data_2 = '0;
      swap_req = 1'b0;
      swap_tid = '0;
      old_cwp = '0;
      new_cwp = '0;
      old_e_cwp = '0;
      new_e_cwp = '0;
      swap_odd = 1'b0;
      swap_local = 1'b0;
      swap_even = 1'b0;
      repeat (3) @(posedge clk);
      #5;
      rst = 1'b0;
      check_ack("swap_ack", swap_ack, 1'b0);
      check_data("rd_data_1", rd_data_1, '0);
      check_data("rd_data_2", rd_data_2, '0);
      check_data("rd_data_3", rd_data_3, '0);

      for (int n = 0; n < irf_pkg::NUM_THREADS; n++) fill_thread(irf_pkg::tid_t'(n));

      repeat (N_RANDOM) begin
         random_traffic(1'b0, '0);
         tick();
      end

      // r0 stays zero even right after a write to it
      repeat (N_ZERO) begin
         thr = pick_tid(1'b0, '0);
         wen_1 = 1'b1;
         wr_tid_1 = thr;
         wr_reg_1 = '0;
         wr_data_1 = rand_bits(DW);
         tid = thr;
         ren_1 = 1'b1;
         rs_1 = '0;
         tick();
         tid = thr;
         ren_1 = 1'b1;
         rs_1 = '0;
         ren_2 = 1'b1;
         rs_2 = '0;
         rs_3 = irf_pkg::reg_addr_t'(rand_bits(5));   // ren_3 low
         tick();
      end

      repeat (N_CONFLICT) begin
         thr = pick_tid(1'b0, '0);
         r = irf_pkg::reg_addr_t'(rand_bits(5));
         if (r == '0) r = 5'd1;
         wen_1 = 1'b1;
         wen_2 = 1'b1;
         wr_tid_1 = thr;
         wr_tid_2 = thr;
         wr_reg_1 = r;
         wr_reg_2 = r;
         wr_data_1 = rand_bits(DW);
         wr_data_2 = rand_bits(DW);
         tick();
         tid = thr;
         ren_1 = 1'b1;
         ren_2 = 1'b1;
         ren_3 = 1'b1;
         rs_1 = r;
         rs_2 = r;
         rs_3 = r;
         tick();
         tick();
      end

      // window A out to the store, refill, then swap B out and A back in
      repeat (N_ROUNDS) begin
         thr = pick_tid(1'b0, '0);
         cwp_a = irf_pkg::cwp_t'(rand_bits(3));
         e_a = irf_pkg::e_cwp_t'(rand_bits(2));
         grp = 3'(rand_bits(3));
         run_swap(thr, cwp_a, cwp_a ^ 3'b100, e_a, e_a ^ 2'b10, grp);
         fill_thread(thr);
         run_swap(thr, cwp_a ^ 3'b100, cwp_a, e_a ^ 2'b10, e_a, grp);
         read_thread(thr);
      end
      tick();
      tick();

      $display("error count: data %0d, swap_ack %0d", data_errs, ack_errs);
      if (data_errs + ack_errs == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
common/irf_pkg.sv
regfile/irf_active_array.sv
window/irf_window_store.sv
window/irf_swap_engine.sv
source/irf_top.sv
testbench/irf_tb.sv

//--- window/irf_swap_engine.sv
`timescale 1ns/1ps

module irf_swap_engine #(
   parameter int DATA_WIDTH = 72
) (
   input  logic                  clk,
   input  logic                  rst,
   // command and handshake
   input  logic                  swap_req,
   output logic                  swap_ack,
   input  irf_pkg::tid_t         swap_tid,
   input  irf_pkg::cwp_t         old_cwp,
   input  irf_pkg::cwp_t         new_cwp,
   input  irf_pkg::e_cwp_t       old_e_cwp,
   input  irf_pkg::e_cwp_t       new_e_cwp,
   input  logic                  swap_odd,
   input  logic                  swap_local,
   input  logic                  swap_even,
   // active array port
   output irf_pkg::thr_reg_t     eng_rd_addr,
   input  logic [DATA_WIDTH-1:0] eng_rd_data,
   output logic                  eng_wen,
   output irf_pkg::thr_reg_t     eng_wr_addr,
   output logic [DATA_WIDTH-1:0] eng_wr_data,
   // window store port
   output irf_pkg::group_t       st_group,
   output logic [7:0]            st_index,
   output logic                  st_wen,
   output logic [DATA_WIDTH-1:0] st_wr_data,
   input  logic [DATA_WIDTH-1:0] st_rd_data
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_SAVE,
      S_RESTORE,
      S_DONE
   } state_t;

   state_t             state;
   logic [2:0]         pend;        // groups still to move indexed by group_t value
   irf_pkg::grp_idx_t  idx;

   // command captured at the start of a swap
   irf_pkg::tid_t      tid_q;
   irf_pkg::cwp_t      old_cwp_q;
   irf_pkg::cwp_t      new_cwp_q;
   irf_pkg::e_cwp_t    old_e_cwp_q;
   irf_pkg::e_cwp_t    new_e_cwp_q;

   irf_pkg::group_t    cur_grp;
   logic [2:0]         cur_mask;
   logic [2:0]         pend_left;
   irf_pkg::reg_addr_t grp_base;
   irf_pkg::reg_addr_t act_reg;
   irf_pkg::cwp_t      cwp_sel;
   irf_pkg::e_cwp_t    e_cwp_sel;
   logic               last;
   logic               start;
   logic               any_grp;

   assign start   = (state == S_IDLE) && swap_req;
   assign any_grp = swap_odd | swap_local | swap_even;
   assign last    = (idx == irf_pkg::grp_idx_t'(irf_pkg::GROUP_SIZE - 1));

   // odd first, then locals, then even
   always_comb begin
      if (pend[0]) begin
         cur_grp = irf_pkg::ODD;
      end else if (pend[1]) begin
         cur_grp = irf_pkg::LOCAL;
      end else begin
         cur_grp = irf_pkg::EVEN;
      end
   end

   assign cur_mask  = 3'b001 << cur_grp;
   assign pend_left = pend & ~cur_mask;

   always_comb begin
      case (cur_grp)
         irf_pkg::ODD:   grp_base = irf_pkg::reg_addr_t'(irf_pkg::ODD_BASE);
         irf_pkg::LOCAL: grp_base = irf_pkg::reg_addr_t'(irf_pkg::LOCAL_BASE);
         default:        grp_base = irf_pkg::reg_addr_t'(irf_pkg::EVEN_BASE);
      endcase
   end

   // save uses the old pointers, restore the new ones
   assign cwp_sel   = (state == S_RESTORE) ? new_cwp_q : old_cwp_q;
   assign e_cwp_sel = (state == S_RESTORE) ? new_e_cwp_q : old_e_cwp_q;

   always_comb begin
      case (cur_grp)
         irf_pkg::LOCAL: st_index = {tid_q, cwp_sel, idx};
         irf_pkg::ODD:   st_index = {1'b0, tid_q, cwp_sel[2:1], idx};
         default:        st_index = {1'b0, tid_q, e_cwp_sel, idx};
      endcase
   end

   assign act_reg     = grp_base | {2'b00, idx};   // bases are multiples of 8
   assign eng_rd_addr = {tid_q, act_reg};
   assign eng_wr_addr = {tid_q, act_reg};
   assign st_group    = cur_grp;

   assign st_wen      = (state == S_SAVE);
   assign st_wr_data  = eng_rd_data;
   assign eng_wen     = (state == S_RESTORE);
   assign eng_wr_data = st_rd_data;

   assign swap_ack    = (state == S_DONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         pend  <= '0;
         idx   <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (start) begin
                  pend  <= {swap_even, swap_local, swap_odd};
                  idx   <= '0;
                  state <= any_grp ? S_SAVE : S_DONE;   // nothing to move so ack at once
               end
            end
            S_SAVE: begin
               idx <= idx + 1'b1;                     // wraps to 0 for the restore pass
               if (last) begin
                  state <= S_RESTORE;
               end
            end
            S_RESTORE: begin
               idx <= idx + 1'b1;
               if (last) begin
                  pend  <= pend_left;
                  state <= (pend_left != '0) ? S_SAVE : S_DONE;
               end
            end
            default: begin
               if (!swap_req) begin
                  state <= S_IDLE;                    // ack drops with the request
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         tid_q       <= swap_tid;
         old_cwp_q   <= old_cwp;
         new_cwp_q   <= new_cwp;
         old_e_cwp_q <= old_e_cwp;
         new_e_cwp_q <= new_e_cwp;
      end
   end

endmodule

//--- window/irf_window_store.sv
`timescale 1ns/1ps

module irf_window_store #(
   parameter int DATA_WIDTH = 72
) (
   input  logic                  clk,
   input  irf_pkg::group_t       st_group,
   input  logic [7:0]            st_index,   // {tid, pointer, offset}
   input  logic                  st_wen,
   input  logic [DATA_WIDTH-1:0] st_wr_data,
   output logic [DATA_WIDTH-1:0] st_rd_data
);

   // locals keep all 8 windows per thread, odd and even only 4
   logic [DATA_WIDTH-1:0] locals [irf_pkg::LOCAL_DEPTH];
   logic [DATA_WIDTH-1:0] odds   [irf_pkg::OUTER_DEPTH];
   logic [DATA_WIDTH-1:0] evens  [irf_pkg::OUTER_DEPTH];

   logic [6:0]            outer_idx;

   assign outer_idx = st_index[6:0];   // top bit is zero for odd/even

   always_ff @(posedge clk) begin
      if (st_wen) begin
         case (st_group)
            irf_pkg::LOCAL: locals[st_index] <= st_wr_data;
            irf_pkg::ODD:   odds[outer_idx]  <= st_wr_data;
            irf_pkg::EVEN:  evens[outer_idx] <= st_wr_data;
            default: ;
         endcase
      end
   end

   // combinational read for the restore step
   always_comb begin
      case (st_group)
         irf_pkg::LOCAL: st_rd_data = locals[st_index];
         irf_pkg::ODD:   st_rd_data = odds[outer_idx];
         irf_pkg::EVEN:  st_rd_data = evens[outer_idx];
         default:        st_rd_data = '0;
      endcase
   end

endmodule
